// ==== sim.f ====
+incdir+verif
hw/branch_pkg.sv
hw/cmp_queue.sv
hw/branch_queue.sv
hw/return_stack.sv
hw/branch_unit.sv
verif/branch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - files:
      - hw/branch_pkg.sv
      - hw/cmp_queue.sv
      - hw/branch_queue.sv
      - hw/return_stack.sv
      - hw/branch_unit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/branch_unit_tb.sv

// ==== verif/branch_unit_table.svh ====
// per row: kind, a, b, use_imm, imm, a_late, a_tag, prediction, addr_on_failure,
// call, ret, pc, then expected failure and return_addr once the branch commits
typedef struct packed {
	cmp_kind_t kind;
	logic [31:0] a;
	logic [31:0] b;
	logic use_imm;
	logic [15:0] imm;
	logic a_late; // a comes later on the CDB
	logic [5:0] a_tag;
	logic [1:0] pred;
	logic [13:0] aof;
	logic call;
	logic ret;
	logic [13:0] pc;
	logic exp_fail;
	logic [13:0] exp_ret;
} row_t;

localparam int n_rows = 13;

row_t table_rows [n_rows] = '{
	'{cmp_e, 32'h0000_0005, 32'h0000_0005, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b11, 14'h0a0, 1'b1, 1'b0, 14'h100, 1'b0, 14'h100},
	'{cmp_le, 32'hffff_fffd, 32'h0000_0002, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b10, 14'h0b1, 1'b1, 1'b0, 14'h200, 1'b0, 14'h200},
	'{cmp_le, 32'h0000_0002, 32'hffff_fffd, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b01, 14'h0c2, 1'b1, 1'b0, 14'h300, 1'b0, 14'h300},
	'{cmp_le, 32'hffff_fff0, 32'hffff_fff0, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b00, 14'h0d3, 1'b0, 1'b0, 14'h000, 1'b1, 14'h300},
	'{cmp_e, 32'hffff_ff85, 32'h0000_0000, 1'b1, 16'hff85, 1'b0, 6'h00,
		2'b11, 14'h0e4, 1'b0, 1'b1, 14'h000, 1'b0, 14'h200},
	'{cmp_le, 32'h0000_0010, 32'h0000_0000, 1'b1, 16'h8000, 1'b0, 6'h00,
		2'b01, 14'h0f5, 1'b0, 1'b1, 14'h000, 1'b0, 14'h100},
	'{cmp_e, 32'h0000_1234, 32'h0000_1234, 1'b0, 16'h0000, 1'b1, 6'h2a,
		2'b10, 14'h106, 1'b0, 1'b0, 14'h000, 1'b0, 14'h100},
	'{cmp_le, 32'hffff_8000, 32'h0000_0000, 1'b0, 16'h0000, 1'b1, 6'h15,
		2'b01, 14'h117, 1'b0, 1'b0, 14'h000, 1'b1, 14'h100},
	'{cmp_fz, 32'h0000_0001, 32'hdead_beef, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b10, 14'h128, 1'b0, 1'b0, 14'h000, 1'b0, 14'h100},
	'{cmp_fz, 32'h3f80_0000, 32'h0000_0000, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b11, 14'h139, 1'b0, 1'b0, 14'h000, 1'b1, 14'h100},
	'{cmp_fz, 32'h8000_0000, 32'h0000_0000, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b01, 14'h14a, 1'b1, 1'b0, 14'h400, 1'b1, 14'h100}, // call undone by flush
	'{cmp_fz, 32'h7f80_0000, 32'h0000_0000, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b00, 14'h15b, 1'b0, 1'b0, 14'h000, 1'b0, 14'h100},
	'{cmp_e, 32'h0000_0001, 32'h0000_0002, 1'b0, 16'h0000, 1'b0, 6'h00,
		2'b00, 14'h16c, 1'b1, 1'b0, 14'h500, 1'b0, 14'h500}
};

// ==== verif/branch_unit_tb.sv ====
`timescale 1ns/1ns

module branch_unit_tb import branch_pkg::*; ();
	logic clk;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	cmp_kind_t cmp_kind;
	logic a_valid;
	logic [tag_w-1:0] a_tag;
	logic [data_w-1:0] a_data;
	logic b_valid;
	logic [tag_w-1:0] b_tag;
	logic [data_w-1:0] b_data;
	logic use_imm;
	logic [imm_w-1:0] imm;
	logic [1:0] prediction;
	logic [addr_w-1:0] addr_on_failure;
	logic cdb_valid;
	logic [tag_w-1:0] cdb_tag;
	logic [data_w-1:0] cdb_data;
	logic commit_valid;
	logic commit_ready;
	logic failure;
	logic [1:0] prediction_end;
	logic [addr_w-1:0] addr_on_failure_out;
	logic call;
	logic ret;
	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] return_addr;
	int errors;
	int timeouts;
	int cur_row;
	integer seed;

	`include "branch_unit_table.svh"

	branch_unit DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic compare_outcome(cmp_kind_t k, logic [31:0] a, logic [31:0] b);
		case (k)
			cmp_e: return a == b;
			cmp_le: return $signed(a) <= $signed(b);
			default: return a[30:23] == 8'h00; // zero exponent, mantissa ignored
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("ERROR %0t: row %0d, %s is %h, expected %h", $time, cur_row, what, got, exp);
	endtask

	task automatic wait_issue_ready();
		int n = 0;
		while (issue_ready !== 1'b1 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (issue_ready !== 1'b1) begin
			timeouts++;
			$display("timeout at %0t: issue_ready never went high", $time);
		end
	endtask

	task automatic wait_commit_ready();
		int n = 0;
		while (commit_ready !== 1'b1 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (commit_ready !== 1'b1) begin
			timeouts++;
			$display("timeout at %0t: commit_ready never went high", $time);
		end
	endtask

	task automatic issue_branch(input cmp_kind_t k, input logic [31:0] a, input logic a_ok,
			input logic [5:0] tag, input logic [31:0] b, input logic imm_sel,
			input logic [15:0] imm_val, input logic [1:0] pred, input logic [13:0] aof);
		wait_issue_ready();
		issue_valid = 1'b1;
		cmp_kind = k;
		a_valid = a_ok;
		a_tag = tag;
		a_data = a_ok ? a : '0; // late value must come from the CDB
		b_valid = 1'b1;
		b_tag = '0;
		b_data = b;
		use_imm = imm_sel;
		imm = imm_val;
		prediction = pred;
		addr_on_failure = aof;
		@(negedge clk);
		issue_valid = 1'b0;
	endtask

	task automatic strobe_cdb(input logic [5:0] tag, input logic [31:0] data);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_data = data;
		@(negedge clk);
		cdb_valid = 1'b0;
	endtask

	task automatic stack_op(input logic do_call, input logic do_ret, input logic [13:0] pc_val);
		call = do_call;
		ret = do_ret;
		pc = pc_val;
		@(negedge clk);
		call = 1'b0;
		ret = 1'b0;
	endtask

	task automatic commit_head(input logic exp_fail, input logic [1:0] exp_pred,
			input logic [13:0] exp_aof);
		wait_commit_ready();
		if (failure !== exp_fail)
			report_mismatch("failure", failure, exp_fail);
		if (prediction_end !== exp_pred)
			report_mismatch("prediction_end", prediction_end, exp_pred);
		if (addr_on_failure_out !== exp_aof)
			report_mismatch("addr_on_failure_out", addr_on_failure_out, exp_aof);
		commit_valid = 1'b1;
		@(negedge clk);
		commit_valid = 1'b0;
		if (exp_fail) begin // mispredict empties the queue
			if (commit_ready !== 1'b0)
				report_mismatch("commit_ready after flush", commit_ready, 1'b0);
			if (issue_ready !== 1'b1)
				report_mismatch("issue_ready after flush", issue_ready, 1'b1);
		end
	endtask

	task automatic run_row(input row_t r);
		issue_branch(r.kind, r.a, !r.a_late, r.a_tag, r.b, r.use_imm, r.imm, r.pred, r.aof);
		if (r.call || r.ret)
			stack_op(r.call, r.ret, r.pc);
		if (r.a_late) begin
			strobe_cdb(r.a_tag ^ 6'h01, ~r.a); // wrong tag, must be ignored
			repeat (2) @(negedge clk);
			if (commit_ready !== 1'b0)
				report_mismatch("commit_ready before operand", commit_ready, 1'b0);
			strobe_cdb(r.a_tag, r.a);
		end
		commit_head(r.exp_fail, r.pred, r.aof);
		if (return_addr !== r.exp_ret)
			report_mismatch("return_addr", return_addr, r.exp_ret);
	endtask

	// random compares, four issued with commit held off, then a fifth
	// that is flushed behind the mispredicted fourth
	task automatic run_fill_rows();
		cmp_kind_t k [5];
		logic [31:0] a [5];
		logic [31:0] b [5];
		logic [1:0] p [5];
		logic res;
		for (int i = 0; i < 5; i++) begin
			k[i] = cmp_kind_t'($unsigned($random(seed)) % 3);
			a[i] = $random(seed);
			b[i] = $random(seed);
			if (b[i][0])
				b[i] = a[i];
			if (k[i] == cmp_fz && a[i][0])
				a[i][30:23] = 8'h00;
			res = compare_outcome(k[i], a[i], b[i]);
			p[i] = {res ^ (i == 3), b[i][1]}; // only the fourth one mispredicts
		end
		for (int i = 0; i < 4; i++)
			issue_branch(k[i], a[i], 1'b1, 6'h00, b[i], 1'b0, 16'h0, p[i], 14'h200 + 14'(i));
		if (issue_ready !== 1'b0)
			report_mismatch("issue_ready with full queue", issue_ready, 1'b0);
		commit_head(1'b0, p[0], 14'h200);
		issue_branch(k[4], a[4], 1'b1, 6'h00, b[4], 1'b0, 16'h0, p[4], 14'h204);
		for (int i = 1; i < 4; i++)
			commit_head(i == 3, p[i], 14'h200 + 14'(i));
		if (return_addr !== 14'h500)
			report_mismatch("return_addr", return_addr, 14'h500);
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		cur_row = 0;
		seed = 32'h07d99735;
		reset = 1'b1;
		issue_valid = 1'b0;
		cmp_kind = cmp_e;
		a_valid = 1'b0;
		a_tag = '0;
		a_data = '0;
		b_valid = 1'b0;
		b_tag = '0;
		b_data = '0;
		use_imm = 1'b0;
		imm = '0;
		prediction = '0;
		addr_on_failure = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		commit_valid = 1'b0;
		call = 1'b0;
		ret = 1'b0;
		pc = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		for (int i = 0; i < n_rows; i++) begin
			cur_row = i;
			run_row(table_rows[i]);
		end
		cur_row = n_rows;
		run_fill_rows();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit import branch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input cmp_kind_t cmp_kind,
	input logic a_valid,
	input logic [tag_w-1:0] a_tag,
	input logic [data_w-1:0] a_data,
	input logic b_valid,
	input logic [tag_w-1:0] b_tag,
	input logic [data_w-1:0] b_data,
	input logic use_imm,
	input logic [imm_w-1:0] imm,
	input logic [1:0] prediction,
	input logic [addr_w-1:0] addr_on_failure,
	input logic cdb_valid,
	input logic [tag_w-1:0] cdb_tag,
	input logic [data_w-1:0] cdb_data,
	input logic commit_valid,
	output logic commit_ready,
	output logic failure,
	output logic [1:0] prediction_end,
	output logic [addr_w-1:0] addr_on_failure_out,
	input logic call,
	input logic ret,
	input logic [addr_w-1:0] pc,
	output logic [addr_w-1:0] return_addr
);
	logic issue_take;
	logic resolve;
	logic resolve_taken;
	logic flush;
	logic [stack_w-1:0] stack_ptr;
	logic [stack_w-1:0] restore_ptr;

	assign issue_take = issue_valid && issue_ready; // accepted compare

	cmp_queue u_cmp_queue (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_take),
		.cmp_kind(cmp_kind),
		.a_valid(a_valid),
		.a_tag(a_tag),
		.a_data(a_data),
		.b_valid(b_valid),
		.b_tag(b_tag),
		.b_data(b_data),
		.use_imm(use_imm),
		.imm(imm),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.flush(flush),
		.resolve(resolve),
		.resolve_taken(resolve_taken)
	);

	branch_queue u_branch_queue (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.prediction(prediction),
		.addr_on_failure(addr_on_failure),
		.stack_ptr(stack_ptr),
		.resolve(resolve),
		.resolve_taken(resolve_taken),
		.commit_valid(commit_valid),
		.issue_ready(issue_ready),
		.commit_ready(commit_ready),
		.failure(failure),
		.prediction_end(prediction_end),
		.addr_on_failure_out(addr_on_failure_out),
		.flush(flush),
		.restore_ptr(restore_ptr)
	);

	return_stack u_return_stack (
		.clk(clk),
		.reset(reset),
		.call(call),
		.ret(ret),
		.pc(pc),
		.flush(flush),
		.restore_ptr(restore_ptr),
		.stack_ptr(stack_ptr),
		.return_addr(return_addr)
	);

endmodule

// ==== hw/return_stack.sv ====
`timescale 1ns/1ns

module return_stack import branch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic call,
	input logic ret,
	input logic [addr_w-1:0] pc,
	input logic flush,
	input logic [stack_w-1:0] restore_ptr,
	output logic [stack_w-1:0] stack_ptr,
	output logic [addr_w-1:0] return_addr
);
	logic [addr_w-1:0] slots [2**stack_w];
	logic [stack_w-1:0] ptr_next;
	logic push;

	assign push = call && !flush; // flush wins over a call

	// pointer wraps around, the stack is circular
	always_comb begin
		if (reset) begin
			ptr_next = '1;
		end else if (flush) begin
			ptr_next = restore_ptr;
		end else if (call) begin
			ptr_next = stack_ptr + 1'b1;
		end else if (ret) begin
			ptr_next = stack_ptr - 1'b1;
		end else begin
			ptr_next = stack_ptr;
		end
	end

	always_ff @(posedge clk) begin
		stack_ptr <= ptr_next;
	end

	always_ff @(posedge clk) begin
		if (push)
			slots[ptr_next] <= pc;
	end

	// pushed pc bypasses the slot write
	always_ff @(posedge clk) begin
		return_addr <= push ? pc : slots[ptr_next];
	end

	assert property (@(posedge clk) disable iff (reset) !(call && ret));

endmodule

// ==== hw/branch_queue.sv ====
`timescale 1ns/1ns

module branch_queue import branch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input logic [1:0] prediction,
	input logic [addr_w-1:0] addr_on_failure,
	input logic [stack_w-1:0] stack_ptr,
	input logic resolve,
	input logic resolve_taken,
	input logic commit_valid,
	output logic issue_ready,
	output logic commit_ready,
	output logic failure,
	output logic [1:0] prediction_end,
	output logic [addr_w-1:0] addr_on_failure_out,
	output logic flush,
	output logic [stack_w-1:0] restore_ptr
);
	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] rptr; // oldest unresolved entry, equals number resolved
	logic [cnt_w-1:0] res_idx;
	logic resolved [n_b_entry];
	logic fail [n_b_entry];
	logic [1:0] pred [n_b_entry];
	logic [addr_w-1:0] aof [n_b_entry];
	logic [stack_w-1:0] snap [n_b_entry];
	logic commit;
	logic take;

	assign commit_ready = (count != '0) && resolved[0];
	assign commit = commit_valid && commit_ready;
	assign flush = commit && fail[0]; // mispredict
	assign issue_ready = !flush && (count < n_b_entry || commit);
	assign take = issue_valid && issue_ready;

	// target index after this cycle's shift
	assign res_idx = rptr - cnt_w'(commit);

	assign failure = fail[0];
	assign prediction_end = pred[0];
	assign addr_on_failure_out = aof[0];
	assign restore_ptr = snap[0];

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			count <= '0;
			rptr <= '0;
		end else begin
			count <= count - cnt_w'(commit) + cnt_w'(take);
			rptr <= rptr - cnt_w'(commit) + cnt_w'(resolve);
		end
	end

	always_ff @(posedge clk) begin
		int src;
		for (int i = 0; i < n_b_entry; i++) begin
			src = i + int'(commit);
			if (reset || flush) begin
				resolved[i] <= 1'b0;
				fail[i] <= 1'b0;
			end else if (src < count) begin
				resolved[i] <= resolved[src] || (resolve && res_idx == i);
				fail[i] <= fail[src]
					|| (resolve && res_idx == i && resolve_taken != pred[src][1]);
			end else begin
				resolved[i] <= 1'b0; // fresh entry
				fail[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		int src;
		for (int i = 0; i < n_b_entry; i++) begin
			src = i + int'(commit);
			if (src < count) begin
				pred[i] <= pred[src];
				aof[i] <= aof[src];
				snap[i] <= snap[src];
			end else begin
				pred[i] <= prediction;
				aof[i] <= addr_on_failure;
				snap[i] <= stack_ptr; // stack pointer as seen at issue
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) count <= n_b_entry);

	// compare queue never runs ahead of the unresolved branches
	assert property (@(posedge clk) disable iff (reset) resolve |-> rptr < count);

endmodule

// ==== hw/cmp_queue.sv ====
`timescale 1ns/1ns

module cmp_queue import branch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input cmp_kind_t cmp_kind,
	input logic a_valid,
	input logic [tag_w-1:0] a_tag,
	input logic [data_w-1:0] a_data,
	input logic b_valid,
	input logic [tag_w-1:0] b_tag,
	input logic [data_w-1:0] b_data,
	input logic use_imm,
	input logic [imm_w-1:0] imm,
	input logic cdb_valid,
	input logic [tag_w-1:0] cdb_tag,
	input logic [data_w-1:0] cdb_data,
	input logic flush,
	output logic resolve,
	output logic resolve_taken
);
	logic [cnt_w-1:0] count;
	cmp_kind_t kind [n_b_entry];
	logic opd_v [n_b_entry][2];
	logic [tag_w-1:0] opd_t [n_b_entry][2];
	opd_word_t opd_d [n_b_entry][2];
	logic upd_v [n_b_entry][2]; // after CDB snoop
	opd_word_t upd_d [n_b_entry][2];
	logic raw_v [2];
	logic [data_w-1:0] raw_d [2];
	logic new_v [2];
	logic [tag_w-1:0] new_t [2];
	opd_word_t new_d [2];
	logic [data_w-1:0] imm_ext;

	assign imm_ext = {{(data_w - imm_w){imm[imm_w-1]}}, imm};

	assign raw_v[0] = a_valid;
	assign raw_d[0] = a_data;
	assign new_t[0] = a_tag;
	assign raw_v[1] = use_imm || b_valid; // immediate is always there
	assign raw_d[1] = use_imm ? imm_ext : b_data;
	assign new_t[1] = b_tag;

	// an issuing compare also catches a broadcast in its own cycle
	always_comb begin
		for (int j = 0; j < 2; j++) begin
			new_v[j] = raw_v[j] || (cdb_valid && new_t[j] == cdb_tag);
			new_d[j] = raw_v[j] ? raw_d[j] : cdb_data;
		end
	end

	always_comb begin
		for (int i = 0; i < n_b_entry; i++) begin
			for (int j = 0; j < 2; j++) begin
				upd_v[i][j] = opd_v[i][j] || (cdb_valid && opd_t[i][j] == cdb_tag);
				upd_d[i][j] = opd_v[i][j] ? opd_d[i][j] : opd_word_t'(cdb_data);
			end
		end
	end

	// head fires in order; fz needs no b
	assign resolve = (count != '0) && opd_v[0][0] && (kind[0] == cmp_fz || opd_v[0][1]);

	always_comb begin
		case (kind[0])
			cmp_e: resolve_taken = opd_d[0][0].int_v == opd_d[0][1].int_v;
			cmp_le: resolve_taken = opd_d[0][0].int_v <= opd_d[0][1].int_v;
			cmp_fz: resolve_taken = opd_d[0][0].flt.exp == '0; // mantissa ignored
			default: resolve_taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			count <= '0;
		end else begin
			count <= count + cnt_w'(issue_valid) - cnt_w'(resolve);
		end
	end

	// shift out the head on resolve, new compare lands behind the last one
	always_ff @(posedge clk) begin
		int src;
		for (int i = 0; i < n_b_entry; i++) begin
			src = i + int'(resolve);
			if (src < count) begin
				kind[i] <= kind[src];
				for (int j = 0; j < 2; j++) begin
					opd_v[i][j] <= upd_v[src][j];
					opd_t[i][j] <= opd_t[src][j];
					opd_d[i][j] <= upd_d[src][j];
				end
			end else begin
				kind[i] <= cmp_kind;
				for (int j = 0; j < 2; j++) begin
					opd_v[i][j] <= new_v[j];
					opd_t[i][j] <= new_t[j];
					opd_d[i][j] <= new_d[j];
				end
			end
		end
	end

	// no issue into a full queue unless the head leaves
	assert property (@(posedge clk) disable iff (reset)
		issue_valid |-> count < n_b_entry || resolve);

endmodule

// ==== hw/branch_pkg.sv ====
package branch_pkg;

	localparam int n_b_entry = 4; // compare queue and branch queue depth
	localparam int cnt_w = $clog2(n_b_entry) + 1; // counts 0..n_b_entry
	localparam int data_w = 32;
	localparam int tag_w = 6;
	localparam int imm_w = 16;
	localparam int addr_w = 14;
	localparam int stack_w = 3; // 8 return stack slots

	typedef enum logic [1:0] {
		cmp_e,  // integer equal
		cmp_le, // signed integer less-or-equal
		cmp_fz  // float is zero
	} cmp_kind_t;

	// one operand word, read as an integer or as a single precision float
	typedef union packed {
		logic signed [data_w-1:0] int_v;
		struct packed {
			logic sign;
			logic [7:0] exp;
			logic [22:0] mant;
		} flt;
	} opd_word_t;

endpackage
